/* lsu_subsystem.f */
source/lsu_pkg.sv
source/dbus_if.sv
source/agu.sv
source/dmem_extender.sv
source/loadstore_unit.sv
source/data_ram.sv
source/lsu_subsystem.sv
sim/lsu_subsystem_tb.sv

/* sim/lsu_subsystem_tb.sv */
`timescale 1ns/1ps

module lsu_subsystem_tb;
  import lsu_pkg::*;

  localparam int CLK_PERIOD = 4;   // Clock period in ns
  localparam int NUM_OPS    = 80;  // Upper bound on the operations issued by all tests
  localparam int WAIT_LIMIT = 8;   // Cycles to wait for a response before giving up
  localparam int TIMEOUT_NS = (NUM_OPS * 10 + 50) * CLK_PERIOD;  // Ten cycles per op plus margin

  logic                  CLK;
  logic                  nRST;
  logic                  issue;
  logic                  flush;
  logic                  halt;
  logic [WORD_W-1:0]     port_a;
  logic [WORD_W-1:0]     port_b;
  logic [WORD_W-1:0]     store_data;
  load_t                 load_type;
  logic                  dren;
  logic                  dwen;
  logic                  wen;
  logic [REG_ADDR_W-1:0] reg_rd;
  logic                  busy;
  logic                  misaligned;
  logic                  wb_en;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [WORD_W-1:0]     wb_data;

  logic [7:0]  ref_mem [1024];          // Byte image of the RAM, indexed by addr[9:0]
  logic [31:0] lfsr = 32'h29ed_619c;   // Fibonacci LFSR state
  int          errors = 0;
  int          checks = 0;

  lsu_subsystem lsu_subsystem_i (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

  // Taps 32, 22, 2 and 1; one step per bit handed out
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  function automatic int access_size(input load_t lt);
    case (lt)
      LB, LBU: return 1;
      LH, LHU: return 2;
      default: return 4;
    endcase
  endfunction

  // Replicate by width, enable the addressed lanes, then reverse lanes on writes if required
  task automatic apply_store(input load_t lt, input logic [31:0] addr, input logic [31:0] sd);
    int         sz;
    int         off;
    int         src;
    logic [7:0] repl [4];
    sz  = access_size(lt);
    off = addr[1:0];
    for (int i = 0; i < 4; i++) repl[i] = sd[8*(i % sz) +: 8];
    for (int j = 0; j < 4; j++) begin
      src = BUS_LITTLE_ENDIAN ? 3 - j : j;  // Bus lane j carries standard lane src
      if (src >= off && src < off + sz) ref_mem[addr[9:2] * 4 + j] = repl[src];
    end
  endtask

  // Loads see the stored word with standard lanes and extend by type
  function automatic logic [31:0] expected_load(input load_t lt, input logic [31:0] addr);
    logic [31:0] word;
    logic [31:0] val;
    for (int j = 0; j < 4; j++) word[8*j +: 8] = ref_mem[addr[9:2] * 4 + j];
    val = word >> (8 * addr[1:0]);
    case (lt)
      LB:      return {{24{val[7]}}, val[7:0]};
      LBU:     return {24'd0, val[7:0]};
      LH:      return {{16{val[15]}}, val[15:0]};
      LHU:     return {16'd0, val[15:0]};
      default: return word;
    endcase
  endfunction

  // Drives one issue pulse and returns 1 ns after the capturing edge
  task automatic start_op(input load_t lt, input logic rd_en, input logic wr_en,
                          input logic w_en, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] sd, input logic [4:0] rd);
    load_type  = lt;
    dren       = rd_en;
    dwen       = wr_en;
    wen        = w_en;
    port_a     = a;
    port_b     = b;
    store_data = sd;
    reg_rd     = rd;
    issue      = 1'b1;
    @(posedge CLK);
    #1;
    issue = 1'b0;
    dren  = 1'b0;
    dwen  = 1'b0;
    wen   = 1'b0;
  endtask

  // Latency counts edges after the issue edge; zero means nothing arrived
  task automatic wait_writeback(output int lat, output logic [31:0] data, output logic [4:0] rd);
    lat  = 0;
    data = '0;
    rd   = '0;
    for (int c = 1; c <= WAIT_LIMIT; c++) begin
      @(negedge CLK);
      if (wb_en) begin
        lat  = c;
        data = wb_data;
        rd   = wb_rd;
        break;
      end
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic run_store(input load_t lt, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] sd);
    int done_cycle;
    done_cycle = 0;
    start_op(lt, 1'b0, 1'b1, 1'b0, a, b, sd, 5'd0);
    for (int c = 1; c <= WAIT_LIMIT; c++) begin
      @(negedge CLK);
      check_value("wb_en", 1'b0, wb_en);  // Stores never write back
      if (!busy) begin
        done_cycle = c;
        break;
      end
    end
    if (done_cycle == 0) begin
      errors++;
      $display("Store to %h never completed: busy stayed high at %0t", a + b, $time);
    end
    check_value("store latency", 2, done_cycle);
    @(posedge CLK);
    #1;
    apply_store(lt, a + b, sd);
  endtask

  task automatic run_load(input load_t lt, input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] rd);
    int          lat;
    logic [31:0] data;
    logic [4:0]  got_rd;
    start_op(lt, 1'b1, 1'b0, 1'b1, a, b, 32'd0, rd);
    wait_writeback(lat, data, got_rd);
    if (lat == 0) begin
      errors++;
      $display("Load from %h gave no writeback at %0t", a + b, $time);
    end else begin
      check_value("load latency", 2, lat);
      check_value("wb_data", expected_load(lt, a + b), data);
      check_value("wb_rd", rd, got_rd);
    end
  endtask

  task automatic run_misaligned(input load_t lt, input logic [31:0] a, input logic [31:0] b,
                                input logic is_load);
    start_op(lt, is_load, ~is_load, is_load, a, b, next_bits(32), next_bits(5));
    @(negedge CLK);
    check_value("misaligned", 1'b1, misaligned);
    check_value("wb_en", 1'b0, wb_en);
    check_value("busy", 1'b0, busy);    // No bus request goes out
    @(posedge CLK);
    #1;
    @(negedge CLK);
    check_value("misaligned", 1'b0, misaligned);  // Raised for one cycle only
    check_value("wb_en", 1'b0, wb_en);
    @(posedge CLK);
    #1;
  endtask

  task automatic test_word_round_trip();
    logic [31:0] addr_q [$];
    logic [31:0] addr;
    for (int i = 0; i < 8; i++) begin
      addr = next_bits(32) & 32'hffff_fffc;  // Upper bits beyond the RAM are ignored
      addr_q.push_back(addr);
      run_store(LW, addr, 32'd0, next_bits(32));
    end
    foreach (addr_q[i]) run_load(LW, addr_q[i], 32'd0, next_bits(5));
  endtask

  task automatic test_byte_half_loads();
    logic [31:0] base;
    for (int w = 0; w < 2; w++) begin
      base = next_bits(32) & 32'hffff_fffc;
      run_store(LW, base, 32'd0, next_bits(32));
      for (int off = 0; off < 4; off++) begin
        run_load(LB, base, off, next_bits(5));
        run_load(LBU, base, off, next_bits(5));
      end
      for (int off = 0; off < 4; off += 2) begin
        run_load(LH, base, off, next_bits(5));
        run_load(LHU, base, off, next_bits(5));
      end
    end
  endtask

  task automatic test_subword_stores();
    logic [31:0] base;
    logic [31:0] off;
    load_t       lt;
    for (int i = 0; i < 8; i++) begin
      base = next_bits(3) << 2;  // A small window so that stores overlap
      if (next_bits(1)) begin
        lt  = LH;
        off = next_bits(1) << 1;
      end else begin
        lt  = LB;
        off = next_bits(2);
      end
      run_store(lt, base, off, next_bits(32));
      run_load(LW, base, 32'd0, next_bits(5));
    end
  endtask

  task automatic test_misaligned();
    logic [31:0] base;
    base = next_bits(32) & 32'hffff_fffc;
    run_store(LW, base, 32'd0, next_bits(32));
    run_misaligned(LH, base, 32'd1, 1'b1);
    run_misaligned(LW, base, 32'd2, 1'b1);
    run_misaligned(LW, base, 32'd3, 1'b0);  // Stores must leave the word alone too
    run_misaligned(LH, base, 32'd3, 1'b0);
    run_load(LW, base, 32'd0, next_bits(5));
  endtask

  // Either kill input drops a pending store before it reaches the RAM
  task automatic flush_store(input logic use_halt);
    logic [31:0] addr;
    addr = next_bits(8) << 2;
    start_op(LW, 1'b0, 1'b1, 1'b0, addr, 32'd0, next_bits(32), 5'd0);
    flush = ~use_halt;
    halt  = use_halt;
    @(negedge CLK);
    check_value("busy", 1'b1, busy);
    @(posedge CLK);
    #1;
    flush = 1'b0;
    halt  = 1'b0;
    @(negedge CLK);
    check_value("busy", 1'b0, busy);
    check_value("wb_en", 1'b0, wb_en);
    @(posedge CLK);
    #1;
    run_load(LW, addr, 32'd0, next_bits(5));  // Reference memory was not updated
  endtask

  task automatic test_busy_flush_halt();
    logic [31:0] addr_x;
    logic [31:0] addr_y;
    int          pulses;
    logic [31:0] data;
    addr_x = next_bits(8) << 2;
    addr_y = addr_x + 32'd4;
    pulses = 0;
    data   = '0;
    start_op(LW, 1'b1, 1'b0, 1'b1, addr_x, 32'd0, 32'd0, 5'd7);
    load_type  = LW;                // Stray store pulsed while the load is pending
    dwen       = 1'b1;
    wen        = 1'b1;
    port_a     = addr_y;
    port_b     = 32'd0;
    store_data = next_bits(32);
    issue      = 1'b1;
    @(negedge CLK);
    check_value("busy", 1'b1, busy);
    check_value("wb_en", 1'b0, wb_en);
    @(posedge CLK);
    #1;
    issue = 1'b0;
    dwen  = 1'b0;
    wen   = 1'b0;
    for (int c = 0; c < 4; c++) begin
      @(negedge CLK);
      if (wb_en) begin
        pulses++;
        data = wb_data;
      end
    end
    check_value("wb_en pulses", 1, pulses);
    check_value("wb_data", expected_load(LW, addr_x), data);
    @(posedge CLK);
    #1;
    run_load(LW, addr_y, 32'd0, next_bits(5));
    flush_store(1'b0);
    flush_store(1'b1);
  endtask

  task automatic test_alu_writeback();
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  rd;
    int          lat;
    logic [31:0] data;
    logic [4:0]  got_rd;
    for (int i = 0; i < 4; i++) begin
      a  = next_bits(32);
      b  = next_bits(32);
      rd = next_bits(5);
      start_op(LW, 1'b0, 1'b0, 1'b1, a, b, 32'd0, rd);
      wait_writeback(lat, data, got_rd);
      if (lat == 0) begin
        errors++;
        $display("Register operation gave no writeback at %0t", $time);
      end else begin
        check_value("alu latency", 1, lat);
        check_value("wb_data", a + b, data);
        check_value("wb_rd", rd, got_rd);
      end
    end
  endtask

  initial begin
    nRST       = 1'b0;
    issue      = 1'b0;
    flush      = 1'b0;
    halt       = 1'b0;
    port_a     = '0;
    port_b     = '0;
    store_data = '0;
    load_type  = LW;
    dren       = 1'b0;
    dwen       = 1'b0;
    wen        = 1'b0;
    reg_rd     = '0;
    for (int i = 0; i < 1024; i++) ref_mem[i] = 8'h00;  // RAM resets to zero
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    check_value("busy", 1'b0, busy);
    check_value("misaligned", 1'b0, misaligned);
    check_value("wb_en", 1'b0, wb_en);
    @(posedge CLK);
    #1;
    test_word_round_trip();
    test_byte_half_loads();
    test_subword_stores();
    test_misaligned();
    test_busy_flush_halt();
    test_alu_writeback();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* source/agu.sv */
`timescale 1ns/1ps

module agu (
  input  logic [lsu_pkg::WORD_W-1:0] port_a,
  input  logic [lsu_pkg::WORD_W-1:0] port_b,
  input  lsu_pkg::load_t             load_type,
  output logic [lsu_pkg::ADDR_W-1:0] address,
  output logic [3:0]                 byte_en_standard,
  output logic                       mal_addr
);
  import lsu_pkg::*;

  logic [1:0] offset;  // Byte offset inside the addressed word

  assign address = port_a + port_b;  // Base plus offset, wraps like the ALU add
  assign offset  = address[1:0];

  // Lane 0 is the least significant byte of the word
  always_comb begin
    byte_en_standard = 4'b0000;  // Unknown types touch no lanes
    mal_addr         = 1'b0;
    case (load_type)
      LB, LBU: begin
        byte_en_standard = 4'b0001 << offset;  // Any offset is legal for a byte
      end
      LH, LHU: begin
        byte_en_standard = offset[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
        mal_addr         = offset[0];                      // Half must sit on an even byte
      end
      LW: begin
        byte_en_standard = 4'b1111;
        mal_addr         = |offset;  // Word must be word aligned
      end
      default: begin
        byte_en_standard = 4'b0000;
        mal_addr         = 1'b0;
      end
    endcase
  end

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
  input  logic CLK,
  input  logic nRST,
  dbus_if.mem  bus
);
  import lsu_pkg::*;

  logic [WORD_W-1:0]    mem [RAM_WORDS];  // Word organized storage
  logic [RAM_IDX_W-1:0] word_idx;         // Word index from addr[9:2], upper bits ignored
  logic                 req;              // A read or write is being asked for
  logic                 phase;            // 0 in the wait cycle, 1 in the completing cycle

  assign word_idx = bus.addr[RAM_IDX_W+1:2];
  assign req      = bus.ren | bus.wen;

  // One wait state, busy only in the first cycle of each request
  assign bus.busy = req & ~phase;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      phase <= 1'b0;
    end else if (req) begin
      phase <= ~phase;  // Wait then complete, then ready for the next request
    end else begin
      phase <= 1'b0;    // A dropped request restarts the count
    end
  end

  // Contents start cleared and take enabled bytes in the completing cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int w = 0; w < RAM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (bus.wen && phase) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.byte_en[i]) begin
          mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];  // Untouched lanes keep their data
        end
      end
    end
  end

  // Reads are asynchronous, the requester only samples in the completing cycle
  assign bus.rdata = mem[word_idx];

endmodule

/* source/dbus_if.sv */
`timescale 1ns/1ps

interface dbus_if;
  import lsu_pkg::*;

  logic [ADDR_W-1:0] addr;     // Byte address of the access
  logic [WORD_W-1:0] wdata;    // Store data, already lane placed
  logic [WORD_W-1:0] rdata;    // Read word, valid in the completing cycle
  logic              ren;      // Read request, held until busy drops
  logic              wen;      // Write request, held until busy drops
  logic [3:0]        byte_en;  // Active byte lanes of the access
  logic              busy;     // High while the memory is still working on the request

  // Requesting side
  modport cpu (
    output addr, wdata, ren, wen, byte_en,
    input  rdata, busy
  );

  // Responding side
  modport mem (
    input  addr, wdata, ren, wen, byte_en,
    output rdata, busy
  );

endinterface

/* source/dmem_extender.sv */
`timescale 1ns/1ps

module dmem_extender (
  input  logic [lsu_pkg::WORD_W-1:0] dmem_in,
  input  lsu_pkg::load_t             load_type,
  input  logic [3:0]                 byte_en,
  output logic [lsu_pkg::WORD_W-1:0] ext_out
);
  import lsu_pkg::*;

  data_word_u rd_word;  // Read word seen as byte or half lanes
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  assign rd_word.word = dmem_in;

  // Pick the lane named by the one-hot byte enable
  always_comb begin
    case (byte_en)
      4'b0010: sel_byte = rd_word.bytes[1];
      4'b0100: sel_byte = rd_word.bytes[2];
      4'b1000: sel_byte = rd_word.bytes[3];
      default: sel_byte = rd_word.bytes[0];  // Lane 0 also covers an unexpected mask
    endcase
  end

  assign sel_half = (byte_en == 4'b1100) ? rd_word.halves[1] : rd_word.halves[0];

  // Extend to a full register value
  always_comb begin
    case (load_type)
      LB:      ext_out = {{(WORD_W-8){sel_byte[7]}}, sel_byte};
      LBU:     ext_out = {{(WORD_W-8){1'b0}}, sel_byte};
      LH:      ext_out = {{(WORD_W-16){sel_half[15]}}, sel_half};
      LHU:     ext_out = {{(WORD_W-16){1'b0}}, sel_half};
      LW:      ext_out = rd_word.word;  // Whole word goes through untouched
      default: ext_out = rd_word.word;
    endcase
  end

endmodule

/* source/loadstore_unit.sv */
`timescale 1ns/1ps

module loadstore_unit (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic                           issue,
  input  logic                           flush,
  input  logic                           halt,
  input  logic [lsu_pkg::WORD_W-1:0]     port_a,
  input  logic [lsu_pkg::WORD_W-1:0]     port_b,
  input  logic [lsu_pkg::WORD_W-1:0]     store_data,
  input  lsu_pkg::load_t                 load_type,
  input  logic                           dren,
  input  logic                           dwen,
  input  logic                           wen,
  input  logic [lsu_pkg::REG_ADDR_W-1:0] reg_rd,
  dbus_if.cpu                            bus,
  output logic                           busy,
  output logic                           misaligned,
  output logic                           wb_en,
  output logic [lsu_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [lsu_pkg::WORD_W-1:0]     wb_data
);
  import lsu_pkg::*;

  // Issue side, straight from the AGU
  logic [ADDR_W-1:0] address_d;
  logic [3:0]        byte_en_d;
  logic              mal_d;
  logic              accept;  // Issue taken into the stage this edge

  // Stage control, cleared by reset, flush and halt
  logic dren_q;
  logic dwen_q;
  logic wen_q;
  logic mal_q;

  // Stage payload, only loaded on accept
  logic [ADDR_W-1:0]     address_q;
  logic [WORD_W-1:0]     store_data_q;
  logic [3:0]            byte_en_q;
  load_t                 load_type_q;
  logic [REG_ADDR_W-1:0] reg_rd_q;

  data_word_u        store_repl;   // Store data copied into every lane of its width
  data_word_u        store_lanes;  // Store data as placed on the bus
  logic [WORD_W-1:0] load_ext;     // Extended load result

  agu agu_i (
    .port_a           (port_a),
    .port_b           (port_b),
    .load_type        (load_type),
    .address          (address_d),
    .byte_en_standard (byte_en_d),
    .mal_addr         (mal_d)
  );

  assign busy   = bus.busy;        // Memory still working, the stage must hold
  assign accept = issue & ~busy;   // Issue while busy is dropped, upstream holds it

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dren_q <= 1'b0;
      dwen_q <= 1'b0;
      wen_q  <= 1'b0;
      mal_q  <= 1'b0;
    end else if (flush || halt) begin  // Kill the stage, even mid access
      dren_q <= 1'b0;
      dwen_q <= 1'b0;
      wen_q  <= 1'b0;
      mal_q  <= 1'b0;
    end else if (accept) begin
      dren_q <= dren;
      dwen_q <= dwen;
      wen_q  <= wen;
      mal_q  <= mal_d & (dren | dwen);  // Only memory operations can be misaligned
    end else if (!busy) begin
      // Bus done, writeback given or fault reported, so the stage empties
      dren_q <= 1'b0;
      dwen_q <= 1'b0;
      wen_q  <= 1'b0;
      mal_q  <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      address_q    <= address_d;
      store_data_q <= store_data;
      byte_en_q    <= byte_en_d;
      load_type_q  <= load_type;
      reg_rd_q     <= reg_rd;
    end
  end

  // A misaligned access never reaches the bus
  assign bus.ren  = dren_q & ~mal_q;
  assign bus.wen  = dwen_q & ~mal_q;
  assign bus.addr = address_q;

  // Store width comes from the same type field as loads
  always_comb begin
    case (load_type_q)
      LB, LBU: store_repl.word = {4{store_data_q[7:0]}};
      LH, LHU: store_repl.word = {2{store_data_q[15:0]}};
      default: store_repl.word = store_data_q;
    endcase
  end

  // Writes go out lane reversed on a little-endian bus, reads keep the standard mask
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (BUS_LITTLE_ENDIAN && dwen_q) begin
        bus.byte_en[i]       = byte_en_q[3-i];
        store_lanes.bytes[i] = store_repl.bytes[3-i];
      end else begin
        bus.byte_en[i]       = byte_en_q[i];
        store_lanes.bytes[i] = store_repl.bytes[i];
      end
    end
  end

  assign bus.wdata = store_lanes.word;

  dmem_extender dmem_extender_i (
    .dmem_in   (bus.rdata),
    .load_type (load_type_q),
    .byte_en   (byte_en_q),
    .ext_out   (load_ext)
  );

  // Loads write back in the completing bus cycle, other ops one cycle after issue
  assign wb_en      = wen_q & ~mal_q & (dren_q ? ~bus.busy : ~dwen_q);
  assign wb_rd      = reg_rd_q;
  assign wb_data    = dren_q ? load_ext : address_q;  // Non-memory result is the AGU sum
  assign misaligned = mal_q;

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

  // Datapath widths
  localparam int WORD_W     = 32;  // Data word width on the bus and in the register file
  localparam int ADDR_W     = 32;  // Byte address width on the data bus
  localparam int REG_ADDR_W = 5;   // Register file index width

  // Data memory geometry
  localparam int RAM_WORDS  = 256;                // Depth of the data RAM in words
  localparam int RAM_IDX_W  = $clog2(RAM_WORDS);  // Word index bits taken from addr[9:2]

  // When set, write lanes are reversed on the bus so that memory sees big-endian order
  localparam bit BUS_LITTLE_ENDIAN = 1'b1;

  // Access width and extension; stores reuse it as their width
  typedef enum logic [2:0] {
    LB  = 3'd0,  // Byte, sign extended
    LH  = 3'd1,  // Half, sign extended
    LW  = 3'd2,  // Full word
    LBU = 3'd3,  // Byte, zero extended
    LHU = 3'd4   // Half, zero extended
  } load_t;

  // One bus word seen either whole, as four byte lanes or as two half lanes
  // Lane 0 is the least significant in both views
  typedef union packed {
    logic [WORD_W-1:0]  word;    // Whole word
    logic [3:0][7:0]    bytes;   // Byte lanes
    logic [1:0][15:0]   halves;  // Half lanes
  } data_word_u;

endpackage

/* source/lsu_subsystem.sv */
`timescale 1ns/1ps

module lsu_subsystem (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic                           issue,
  input  logic                           flush,
  input  logic                           halt,
  input  logic [lsu_pkg::WORD_W-1:0]     port_a,
  input  logic [lsu_pkg::WORD_W-1:0]     port_b,
  input  logic [lsu_pkg::WORD_W-1:0]     store_data,
  input  lsu_pkg::load_t                 load_type,
  input  logic                           dren,
  input  logic                           dwen,
  input  logic                           wen,
  input  logic [lsu_pkg::REG_ADDR_W-1:0] reg_rd,
  output logic                           busy,
  output logic                           misaligned,
  output logic                           wb_en,
  output logic [lsu_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [lsu_pkg::WORD_W-1:0]     wb_data
);

  dbus_if bus_if ();  // Data bus between the unit and the RAM

  loadstore_unit loadstore_unit_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .issue      (issue),
    .flush      (flush),
    .halt       (halt),
    .port_a     (port_a),
    .port_b     (port_b),
    .store_data (store_data),
    .load_type  (load_type),
    .dren       (dren),
    .dwen       (dwen),
    .wen        (wen),
    .reg_rd     (reg_rd),
    .bus        (bus_if.cpu),
    .busy       (busy),
    .misaligned (misaligned),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  data_ram data_ram_i (
    .CLK  (CLK),
    .nRST (nRST),
    .bus  (bus_if.mem)
  );

endmodule
